//--- verilog/soc_pkg.sv
//------------------------------
// Address map, register offsets and widths of the peripheral bus
// Slaves are decoded on the top DEC_W address bits only
// Register offsets are byte offsets, word aligned
//------------------------------
package soc_pkg;

	// Wishbone widths
	localparam int DATA_W = 32;
	localparam int ADR_W  = 32;
	localparam int SEL_W  = 4;

	// Slave decode values of the upper address bits
	localparam int DEC_W = 15;
	localparam logic [DEC_W-1:0] BRAM_BASE  = 15'h0000;
	localparam logic [DEC_W-1:0] TIMER_BASE = 15'h7001;
	localparam logic [DEC_W-1:0] GPIO_BASE  = 15'h7002;

	// Block RAM, byte address width and depth in words
	localparam int BRAM_ADR_W = 12;
	localparam int BRAM_WORDS = 1 << (BRAM_ADR_W - 2);

	//------------------------------
	// Register layout
	//------------------------------
	localparam int REG_OFS_W = 8;
	localparam int TMR_CH    = 2;

	// Timer, one group of three per channel
	localparam logic [REG_OFS_W-1:0] TMR_CTRL0 = 8'h00;
	localparam logic [REG_OFS_W-1:0] TMR_CMP0  = 8'h04;
	localparam logic [REG_OFS_W-1:0] TMR_CNT0  = 8'h08;
	localparam logic [REG_OFS_W-1:0] TMR_CTRL1 = 8'h10;
	localparam logic [REG_OFS_W-1:0] TMR_CMP1  = 8'h14;
	localparam logic [REG_OFS_W-1:0] TMR_CNT1  = 8'h18;

	// Timer control bits
	localparam int CTRL_EN  = 0;
	localparam int CTRL_AR  = 1;
	localparam int CTRL_IRQ = 3;

	// GPIO
	localparam logic [REG_OFS_W-1:0] GPIO_IN   = 8'h00;
	localparam logic [REG_OFS_W-1:0] GPIO_OUT  = 8'h04;
	localparam logic [REG_OFS_W-1:0] GPIO_MASK = 8'h08;
	localparam int BTN_W   = 4;
	localparam int BTN_LSB = 8;
	localparam int LED_W   = 8;

	// Seven-segment display
	localparam int SEG_SCAN_W = 10;
	localparam int SEG_DIGITS = 4;
	localparam int SEG_SEL_W  = 2;
	localparam int SEG_W      = 7;

	// Interrupt vector layout
	localparam int IRQ_TMR0 = 0;
	localparam int IRQ_GPIO = 1;
	localparam int IRQ_TMR1 = 2;
	localparam int IRQ_W    = 3;

endpackage

//--- verilog/bus_decoder.sv
//------------------------------
// One Wishbone master to RAM, timer and GPIO
// Routing is combinational; unmapped access ends with err
// Only one transaction may be in flight
//------------------------------
module bus_decoder (
	input  logic                         clk_i,
	input  logic                         rst_n_i,
	// Master side
	input  logic                         m_cyc_i,
	input  logic                         m_stb_i,
	input  logic                         m_we_i,
	input  logic [soc_pkg::ADR_W-1:0]    m_adr_i,
	input  logic [soc_pkg::SEL_W-1:0]    m_sel_i,
	input  logic [soc_pkg::DATA_W-1:0]   m_dat_i,
	output logic [soc_pkg::DATA_W-1:0]   m_dat_o,
	output logic                         m_ack_o,
	output logic                         m_err_o,
	// Shared slave request lines
	output logic                         s_cyc_o,
	output logic                         s_we_o,
	output logic [soc_pkg::ADR_W-1:0]    s_adr_o,
	output logic [soc_pkg::SEL_W-1:0]    s_sel_o,
	output logic [soc_pkg::DATA_W-1:0]   s_dat_o,
	// Per-slave strobe and response
	output logic                         ram_stb_o,
	input  logic [soc_pkg::DATA_W-1:0]   ram_dat_i,
	input  logic                         ram_ack_i,
	output logic                         tmr_stb_o,
	input  logic [soc_pkg::DATA_W-1:0]   tmr_dat_i,
	input  logic                         tmr_ack_i,
	output logic                         gpio_stb_o,
	input  logic [soc_pkg::DATA_W-1:0]   gpio_dat_i,
	input  logic                         gpio_ack_i
);
	import soc_pkg::*;

	logic [DEC_W-1:0] dec;
	logic             hit_ram;
	logic             hit_tmr;
	logic             hit_gpio;
	logic             miss;
	logic             req;
	logic             err_q;

	//------------------------------
	// Address decode
	//------------------------------
	// Top bits pick the slave
	assign dec      = m_adr_i[ADR_W-1 -: DEC_W];
	assign hit_ram  = (dec == BRAM_BASE);
	assign hit_tmr  = (dec == TIMER_BASE);
	assign hit_gpio = (dec == GPIO_BASE);
	assign miss     = ~(hit_ram | hit_tmr | hit_gpio);
	assign req      = m_cyc_i & m_stb_i;

	// Broadcast to every slave
	assign s_cyc_o = m_cyc_i;
	assign s_we_o  = m_we_i;
	assign s_adr_o = m_adr_i;
	assign s_sel_o = m_sel_i;
	assign s_dat_o = m_dat_i;

	// Strobe only reaches the addressed slave
	assign ram_stb_o  = req & hit_ram;
	assign tmr_stb_o  = req & hit_tmr;
	assign gpio_stb_o = req & hit_gpio;

	//------------------------------
	// Response path
	//------------------------------
	// Address is held until ack, so the hit still selects the right slave
	always_comb begin
		m_dat_o = '0;
		m_ack_o = 1'b0;
		if (hit_ram) begin
			m_dat_o = ram_dat_i;
			m_ack_o = ram_ack_i;
		end else if (hit_tmr) begin
			m_dat_o = tmr_dat_i;
			m_ack_o = tmr_ack_i;
		end else if (hit_gpio) begin
			m_dat_o = gpio_dat_i;
			m_ack_o = gpio_ack_i;
		end
	end

	// Nobody home; err one cycle after stb, never twice for one request
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			err_q <= 1'b0;
		end else begin
			err_q <= req & miss & ~err_q;
		end
	end

	assign m_err_o = err_q;

endmodule

//--- verilog/bram_slave.sv
//------------------------------
// Byte-selectable block RAM, 1024 words
// Read data and ack one cycle after stb
// Contents are not cleared by reset
//------------------------------
module bram_slave (
	input  logic                                 clk_i,
	input  logic                                 rst_n_i,
	input  logic                                 cyc_i,
	input  logic                                 stb_i,
	input  logic                                 we_i,
	input  logic [soc_pkg::BRAM_ADR_W-1:2]       adr_i,
	input  logic [soc_pkg::SEL_W-1:0]            sel_i,
	input  logic [soc_pkg::DATA_W-1:0]           dat_i,
	output logic [soc_pkg::DATA_W-1:0]           dat_o,
	output logic                                 ack_o
);
	import soc_pkg::*;

	logic [DATA_W-1:0] mem [BRAM_WORDS];
	logic              req;

	// New request only; the ack cycle itself is skipped
	assign req = cyc_i & stb_i & ~ack_o;

	//------------------------------
	// Storage
	//------------------------------
	always_ff @(posedge clk_i) begin
		if (req && we_i) begin
			// Only selected byte lanes change
			for (int b = 0; b < SEL_W; b++) begin
				if (sel_i[b]) begin
					mem[adr_i][8*b +: 8] <= dat_i[8*b +: 8];
				end
			end
		end
		// Old word on a write cycle, nobody reads it then
		if (req) begin
			dat_o <= mem[adr_i];
		end
	end

	// Single-cycle ack
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= req;
		end
	end

endmodule

//--- verilog/timer_slave.sv
//------------------------------
// Two compare-match timers, one-shot or auto-reload
// Flag is sticky until a 1 is written to CTRL_IRQ
// Bus writes win over counting in the same cycle
//------------------------------
module timer_slave (
	input  logic                                clk_i,
	input  logic                                rst_n_i,
	input  logic                                cyc_i,
	input  logic                                stb_i,
	input  logic                                we_i,
	input  logic [soc_pkg::REG_OFS_W-1:0]       adr_i,
	input  logic [soc_pkg::DATA_W-1:0]          dat_i,
	output logic [soc_pkg::DATA_W-1:0]          dat_o,
	output logic                                ack_o,
	output logic [soc_pkg::TMR_CH-1:0]          irq_o
);
	import soc_pkg::*;

	logic                req;
	logic                wr;
	logic [TMR_CH-1:0]   wr_ctrl, wr_cmp, wr_cnt;
	logic [TMR_CH-1:0]   en_q, ar_q, flag_q;
	logic [DATA_W-1:0]   cmp_q [TMR_CH];
	logic [DATA_W-1:0]   cnt_q [TMR_CH];
	logic [DATA_W-1:0]   ctrl_rd [TMR_CH];
	logic [DATA_W-1:0]   rd_word;

	assign req = cyc_i & stb_i & ~ack_o;
	assign wr  = req & we_i;

	// Register write strobes, channel 0 in bit 0
	assign wr_ctrl = {wr & (adr_i == TMR_CTRL1), wr & (adr_i == TMR_CTRL0)};
	assign wr_cmp  = {wr & (adr_i == TMR_CMP1),  wr & (adr_i == TMR_CMP0)};
	assign wr_cnt  = {wr & (adr_i == TMR_CNT1),  wr & (adr_i == TMR_CNT0)};

	//------------------------------
	// Counters
	//------------------------------
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			en_q   <= '0;
			ar_q   <= '0;
			flag_q <= '0;
			for (int ch = 0; ch < TMR_CH; ch++) begin
				cmp_q[ch] <= '0;
				cnt_q[ch] <= '0;
			end
		end else begin
			for (int ch = 0; ch < TMR_CH; ch++) begin
				// Match: wrap, flag, stop unless reloading
				if (en_q[ch]) begin
					if (cnt_q[ch] == cmp_q[ch]) begin
						cnt_q[ch]  <= '0;
						flag_q[ch] <= 1'b1;
						if (!ar_q[ch]) begin
							en_q[ch] <= 1'b0;
						end
					end else begin
						cnt_q[ch] <= cnt_q[ch] + 1'b1;
					end
				end
				if (wr_ctrl[ch]) begin
					en_q[ch] <= dat_i[CTRL_EN];
					ar_q[ch] <= dat_i[CTRL_AR];
					// Write one to clear
					if (dat_i[CTRL_IRQ]) begin
						flag_q[ch] <= 1'b0;
					end
				end
				if (wr_cmp[ch]) begin
					cmp_q[ch] <= dat_i;
				end
				if (wr_cnt[ch]) begin
					cnt_q[ch] <= dat_i;
				end
			end
		end
	end

	//------------------------------
	// Read back
	//------------------------------
	always_comb begin
		for (int ch = 0; ch < TMR_CH; ch++) begin
			ctrl_rd[ch]           = '0;
			ctrl_rd[ch][CTRL_EN]  = en_q[ch];
			ctrl_rd[ch][CTRL_AR]  = ar_q[ch];
			ctrl_rd[ch][CTRL_IRQ] = flag_q[ch];
		end
		case (adr_i)
			TMR_CTRL0: rd_word = ctrl_rd[0];
			TMR_CMP0:  rd_word = cmp_q[0];
			TMR_CNT0:  rd_word = cnt_q[0];
			TMR_CTRL1: rd_word = ctrl_rd[1];
			TMR_CMP1:  rd_word = cmp_q[1];
			TMR_CNT1:  rd_word = cnt_q[1];
			default:   rd_word = '0;
		endcase
	end

	// Data sampled with the request, shown with ack
	always_ff @(posedge clk_i) begin
		if (req) begin
			dat_o <= rd_word;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= req;
		end
	end

	// One line per channel, straight from the flag
	assign irq_o = flag_q;

endmodule

//--- verilog/gpio_slave.sv
//------------------------------
// Buttons in, output word out, masked interrupt
// Buttons need two cycles to show in GPIO_IN
// GPIO_IN is read-only
//------------------------------
module gpio_slave (
	input  logic                                clk_i,
	input  logic                                rst_n_i,
	input  logic                                cyc_i,
	input  logic                                stb_i,
	input  logic                                we_i,
	input  logic [soc_pkg::REG_OFS_W-1:0]       adr_i,
	input  logic [soc_pkg::DATA_W-1:0]          dat_i,
	input  logic [soc_pkg::BTN_W-1:0]           btn_i,
	output logic [soc_pkg::DATA_W-1:0]          dat_o,
	output logic                                ack_o,
	output logic [soc_pkg::DATA_W-1:0]          gpio_out_o,
	output logic                                irq_o
);
	import soc_pkg::*;

	logic                req;
	logic [BTN_W-1:0]    btn_meta, btn_sync;
	logic [DATA_W-1:0]   in_word;
	logic [DATA_W-1:0]   out_q, mask_q;
	logic [DATA_W-1:0]   rd_word;

	assign req = cyc_i & stb_i & ~ack_o;

	//------------------------------
	// Input side
	//------------------------------
	// Two-flop synchronizer, buttons are asynchronous
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			btn_meta <= '0;
			btn_sync <= '0;
		end else begin
			btn_meta <= btn_i;
			btn_sync <= btn_meta;
		end
	end

	// Buttons sit at BTN_LSB, the rest reads zero
	assign in_word = DATA_W'(btn_sync) << BTN_LSB;

	// Level interrupt from any unmasked input
	assign irq_o = |(in_word & mask_q);

	//------------------------------
	// Registers
	//------------------------------
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			out_q  <= '0;
			mask_q <= '0;
			ack_o  <= 1'b0;
		end else begin
			ack_o <= req;
			if (req && we_i && adr_i == GPIO_OUT) begin
				out_q <= dat_i;
			end
			if (req && we_i && adr_i == GPIO_MASK) begin
				mask_q <= dat_i;
			end
		end
	end

	always_comb begin
		case (adr_i)
			GPIO_IN:   rd_word = in_word;
			GPIO_OUT:  rd_word = out_q;
			GPIO_MASK: rd_word = mask_q;
			default:   rd_word = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (req) begin
			dat_o <= rd_word;
		end
	end

	assign gpio_out_o = out_q;

endmodule

//--- verilog/sevenseg_scan.sv
//------------------------------
// Four-digit hex display, lowest nibble on digit 0
// Segments and anodes are active low, seg order g..a
//------------------------------
module sevenseg_scan (
	input  logic                                            clk_i,
	input  logic                                            rst_n_i,
	input  logic [4*soc_pkg::SEG_DIGITS-1:0]                value_i,
	output logic [soc_pkg::SEG_W-1:0]                       seg_o,
	output logic [soc_pkg::SEG_DIGITS-1:0]                  an_o
);
	import soc_pkg::*;

	logic [SEG_SCAN_W+SEG_SEL_W-1:0] scan_q;
	logic [SEG_SEL_W-1:0]            digit;
	logic [3:0]                      nibble;

	// Free-running; top bits pick the digit
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			scan_q <= '0;
		end else begin
			scan_q <= scan_q + 1'b1;
		end
	end

	assign digit  = scan_q[SEG_SCAN_W +: SEG_SEL_W];
	assign nibble = value_i[4*digit +: 4];
	assign an_o   = ~(SEG_DIGITS'(1) << digit);

	// Hex glyphs
	always_comb begin
		case (nibble)
			4'h0: seg_o = 7'h40;
			4'h1: seg_o = 7'h79;
			4'h2: seg_o = 7'h24;
			4'h3: seg_o = 7'h30;
			4'h4: seg_o = 7'h19;
			4'h5: seg_o = 7'h12;
			4'h6: seg_o = 7'h02;
			4'h7: seg_o = 7'h78;
			4'h8: seg_o = 7'h00;
			4'h9: seg_o = 7'h10;
			4'ha: seg_o = 7'h08;
			4'hb: seg_o = 7'h03;
			4'hc: seg_o = 7'h46;
			4'hd: seg_o = 7'h21;
			4'he: seg_o = 7'h06;
			default: seg_o = 7'h0e;
		endcase
	end

endmodule

//--- verilog/soc_top.sv
//------------------------------
// Peripheral subsystem behind one Wishbone master port
// Every access ends with ack or err one cycle after stb
//------------------------------
module soc_top (
	input  logic                                    clk_i,
	input  logic                                    rst_n_i,
	input  logic                                    wb_cyc_i,
	input  logic                                    wb_stb_i,
	input  logic                                    wb_we_i,
	input  logic [soc_pkg::ADR_W-1:0]               wb_adr_i,
	input  logic [soc_pkg::SEL_W-1:0]               wb_sel_i,
	input  logic [soc_pkg::DATA_W-1:0]              wb_dat_i,
	output logic [soc_pkg::DATA_W-1:0]              wb_dat_o,
	output logic                                    wb_ack_o,
	output logic                                    wb_err_o,
	input  logic [soc_pkg::BTN_W-1:0]               btn_i,
	output logic [soc_pkg::LED_W-1:0]               led_o,
	output logic [soc_pkg::SEG_W-1:0]               seg_o,
	output logic [soc_pkg::SEG_DIGITS-1:0]          an_o,
	output logic [soc_pkg::IRQ_W-1:0]               irq_o
);
	import soc_pkg::*;

	// Shared request lines
	logic              s_cyc, s_we;
	logic [ADR_W-1:0]  s_adr;
	logic [SEL_W-1:0]  s_sel;
	logic [DATA_W-1:0] s_dat;
	// Per-slave returns
	logic              ram_stb, ram_ack, tmr_stb, tmr_ack, gpio_stb, gpio_ack;
	logic [DATA_W-1:0] ram_dat, tmr_dat, gpio_dat;
	logic [TMR_CH-1:0] tmr_irq;
	logic              gpio_irq;
	logic [DATA_W-1:0] gpio_out;

	//------------------------------
	// Interconnect
	//------------------------------
	bus_decoder u_dec (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.m_cyc_i(wb_cyc_i), .m_stb_i(wb_stb_i), .m_we_i(wb_we_i),
		.m_adr_i(wb_adr_i), .m_sel_i(wb_sel_i), .m_dat_i(wb_dat_i),
		.m_dat_o(wb_dat_o), .m_ack_o(wb_ack_o), .m_err_o(wb_err_o),
		.s_cyc_o(s_cyc), .s_we_o(s_we), .s_adr_o(s_adr), .s_sel_o(s_sel), .s_dat_o(s_dat),
		.ram_stb_o(ram_stb), .ram_dat_i(ram_dat), .ram_ack_i(ram_ack),
		.tmr_stb_o(tmr_stb), .tmr_dat_i(tmr_dat), .tmr_ack_i(tmr_ack),
		.gpio_stb_o(gpio_stb), .gpio_dat_i(gpio_dat), .gpio_ack_i(gpio_ack)
	);

	//------------------------------
	// Slaves
	//------------------------------
	bram_slave u_ram (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .cyc_i(s_cyc), .stb_i(ram_stb), .we_i(s_we),
		.adr_i(s_adr[BRAM_ADR_W-1:2]), .sel_i(s_sel), .dat_i(s_dat),
		.dat_o(ram_dat), .ack_o(ram_ack)
	);

	timer_slave u_tmr (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .cyc_i(s_cyc), .stb_i(tmr_stb), .we_i(s_we),
		.adr_i(s_adr[REG_OFS_W-1:0]), .dat_i(s_dat),
		.dat_o(tmr_dat), .ack_o(tmr_ack), .irq_o(tmr_irq)
	);

	gpio_slave u_gpio (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .cyc_i(s_cyc), .stb_i(gpio_stb), .we_i(s_we),
		.adr_i(s_adr[REG_OFS_W-1:0]), .dat_i(s_dat), .btn_i(btn_i),
		.dat_o(gpio_dat), .ack_o(gpio_ack), .gpio_out_o(gpio_out), .irq_o(gpio_irq)
	);

	// Display shows the low half of the GPIO output
	sevenseg_scan u_seg (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.value_i(gpio_out[4*SEG_DIGITS-1:0]), .seg_o(seg_o), .an_o(an_o)
	);

	assign led_o = gpio_out[LED_W-1:0];

	// Interrupt vector
	assign irq_o[IRQ_TMR0] = tmr_irq[0];
	assign irq_o[IRQ_GPIO] = gpio_irq;
	assign irq_o[IRQ_TMR1] = tmr_irq[1];

endmodule

//--- test/soc_sva.sv
//------------------------------
// Bus response and display rules on soc_top
// Attached by bind, reports through assertion failures only
//------------------------------
module soc_sva (
	input logic                                   clk_i,
	input logic                                   rst_n_i,
	input logic                                   cyc_i,
	input logic                                   stb_i,
	input logic                                   ack_i,
	input logic                                   err_i,
	input logic [soc_pkg::SEG_DIGITS-1:0]         an_i,
	input logic [soc_pkg::IRQ_W-1:0]              irq_i
);
	timeunit 1ns;
	timeprecision 1ps;

	// Never both answers at once
	a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(ack_i && err_i))
		else $error("ack and err high in the same cycle");

	// An answer needs a request one cycle earlier
	a_resp_after_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(ack_i || err_i) |-> $past(cyc_i && stb_i))
		else $error("ack or err without a request in the cycle before");

	// New request is answered in the next cycle
	a_resp_next: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$rose(cyc_i && stb_i) |=> (ack_i || err_i))
		else $error("request not answered in the next cycle");

	// Exactly one digit lit
	a_an_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$onehot(~an_i))
		else $error("anodes not one-hot active low");

	a_irq_reset: assert property (@(posedge clk_i) $rose(rst_n_i) |-> (irq_i == '0))
		else $error("interrupt vector not clear after reset");

endmodule

bind soc_top soc_sva u_sva (
	.clk_i(clk_i), .rst_n_i(rst_n_i), .cyc_i(wb_cyc_i), .stb_i(wb_stb_i),
	.ack_i(wb_ack_o), .err_i(wb_err_o), .an_i(an_o), .irq_i(irq_o)
);

//--- test/tb_soc.sv
//------------------------------
// Testbench for soc_top through its Wishbone master port
// Inputs change and outputs are sampled on the falling edge
// First error stops the run; a watchdog bounds its length
//------------------------------
module tb_soc;
	timeunit 1ns;
	timeprecision 1ps;
	import soc_pkg::*;

	localparam int CLK_PERIOD  = 8;
	localparam int RST_CYCLES  = 4;
	localparam int RAM_TESTS   = 64;
	localparam int WIDX_W      = BRAM_ADR_W - 2;
	localparam int ACK_LIMIT   = 8;
	localparam int POLL_MAX    = 200;
	localparam int ACCESS_CYC  = ACK_LIMIT + 1;
	localparam int SCAN_PERIOD = SEG_DIGITS << SEG_SCAN_W;
	localparam int SHOW_VALUES = 4;
	// Upper bound of each test in cycles
	localparam int RAM_CYC      = 3 * RAM_TESTS * ACCESS_CYC;
	localparam int TIMER_CYC    = 3 * POLL_MAX * ACCESS_CYC;
	localparam int DISPLAY_CYC  = SHOW_VALUES * (SCAN_PERIOD + ACCESS_CYC);
	localparam int WATCHDOG_CYC = RST_CYCLES + RAM_CYC + TIMER_CYC + DISPLAY_CYC + 1000;
	// Bus response as {err, ack}
	localparam logic [1:0] RESP_ACK = 2'b01;
	localparam logic [1:0] RESP_ERR = 2'b10;

	logic                  clk = 1'b0;
	logic                  rst_n;
	logic                  cyc, stb, we;
	logic [ADR_W-1:0]      adr;
	logic [SEL_W-1:0]      sel;
	logic [DATA_W-1:0]     wdat, rdat;
	logic                  ack, err;
	logic [BTN_W-1:0]      btn;
	logic [LED_W-1:0]      led;
	logic [SEG_W-1:0]      seg;
	logic [SEG_DIGITS-1:0] an;
	logic [IRQ_W-1:0]      irq;

	logic [31:0]             rng_state = 32'h90c1_90bf;
	logic [DATA_W-1:0]       ram_model [BRAM_WORDS];
	logic [4*SEG_DIGITS-1:0] seg_value;
	logic                    seg_check_on;
	int unsigned             scan_cyc;

	soc_top uut (
		.clk_i(clk), .rst_n_i(rst_n),
		.wb_cyc_i(cyc), .wb_stb_i(stb), .wb_we_i(we), .wb_adr_i(adr),
		.wb_sel_i(sel), .wb_dat_i(wdat), .wb_dat_o(rdat), .wb_ack_o(ack), .wb_err_o(err),
		.btn_i(btn), .led_o(led), .seg_o(seg), .an_o(an), .irq_o(irq)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Cycles since reset release, paces the expected digit
	always @(posedge clk) begin
		if (!rst_n) begin
			scan_cyc <= 0;
		end else begin
			scan_cyc <= scan_cyc + 1;
		end
	end

	//------------------------------
	// Reference functions
	//------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Byte address of a slave's first register
	function automatic logic [ADR_W-1:0] base_addr(input logic [DEC_W-1:0] base);
		return {base, {(ADR_W - DEC_W){1'b0}}};
	endfunction

	// Every bit of the word index shows up in the pattern
	function automatic logic [DATA_W-1:0] fill_word(input logic [WIDX_W-1:0] idx);
		return {6'h2a, idx, 6'h15, ~idx};
	endfunction

	// Only lanes with sel set take the new byte
	function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
		input logic [DATA_W-1:0] new_w, input logic [SEL_W-1:0] lanes);
		logic [DATA_W-1:0] r;
		r = old_w;
		for (int b = 0; b < SEL_W; b++) begin
			if (lanes[b]) begin
				r[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return r;
	endfunction

	// Active-low hex glyphs in g..a order
	function automatic logic [SEG_W-1:0] glyph(input logic [3:0] n);
		case (n)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0010000;
			4'ha: return 7'b0001000;
			4'hb: return 7'b0000011;
			4'hc: return 7'b1000110;
			4'hd: return 7'b0100001;
			4'he: return 7'b0000110;
			default: return 7'b0001110;
		endcase
	endfunction

	// Digit 0 first, next digit every 2**SEG_SCAN_W cycles
	function automatic logic [SEG_DIGITS-1:0] expected_anodes(input int unsigned cycles);
		logic [SEG_DIGITS-1:0] a;
		int                    d;
		a = '1;
		d = (cycles >> SEG_SCAN_W) % SEG_DIGITS;
		a[d] = 1'b0;
		return a;
	endfunction

	// Nibble that the low anode points at
	function automatic logic [3:0] shown_nibble(input logic [4*SEG_DIGITS-1:0] v,
		input logic [SEG_DIGITS-1:0] anodes);
		case (anodes)
			4'b1110: return v[3:0];
			4'b1101: return v[7:4];
			4'b1011: return v[11:8];
			default: return v[15:12];
		endcase
	endfunction

	//------------------------------
	// Checks and bus tasks
	//------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			abort_run($sformatf("mismatch %s expected %08h actual %08h", name, exp, act));
		end
	endtask

	// One access followed by one idle cycle
	task automatic bus_access(input logic wr, input logic [ADR_W-1:0] a,
		input logic [SEL_W-1:0] lanes, input logic [DATA_W-1:0] d,
		output logic [DATA_W-1:0] q, output logic [1:0] resp);
		int waited;
		cyc = 1'b1;
		stb = 1'b1;
		we = wr;
		adr = a;
		sel = lanes;
		wdat = d;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!(ack || err) && waited < ACK_LIMIT);
		if (!(ack || err)) begin
			abort_run($sformatf("no ack or err for address %08h", a));
		end else begin
			q = rdat;
			resp = {err, ack};
			cyc = 1'b0;
			stb = 1'b0;
			we = 1'b0;
			@(negedge clk);
		end
	endtask

	task automatic write_reg(input logic [ADR_W-1:0] a, input logic [DATA_W-1:0] d);
		logic [DATA_W-1:0] q;
		logic [1:0]        resp;
		bus_access(1'b1, a, '1, d, q, resp);
		compare($sformatf("write resp %08h", a), 32'(RESP_ACK), 32'(resp));
	endtask

	task automatic read_reg(input logic [ADR_W-1:0] a, output logic [DATA_W-1:0] q);
		logic [1:0] resp;
		bus_access(1'b0, a, '1, '0, q, resp);
		compare($sformatf("read resp %08h", a), 32'(RESP_ACK), 32'(resp));
	endtask

	task automatic poll_flag(input logic [ADR_W-1:0] a, input string name);
		logic [DATA_W-1:0] d;
		int                polls;
		polls = 0;
		d = '0;
		while (!d[CTRL_IRQ] && polls < POLL_MAX) begin
			read_reg(a, d);
			polls++;
		end
		if (!d[CTRL_IRQ]) begin
			abort_run($sformatf("%s: timer flag was never set", name));
		end
	endtask

	// Display compared on every cycle while enabled
	always @(negedge clk) begin
		if (seg_check_on) begin
			compare("display anode", 32'(expected_anodes(scan_cyc)), 32'(an));
			compare("display seg",
				32'(glyph(shown_nibble(seg_value, expected_anodes(scan_cyc)))), 32'(seg));
		end
	end

	//------------------------------
	// Test sequence
	//------------------------------
	initial begin : stimulus
		logic [31:0]             r;
		logic [DATA_W-1:0]       q;
		logic [1:0]              resp;
		logic [WIDX_W-1:0]       ram_idx [RAM_TESTS];
		logic [SEL_W-1:0]        lanes;
		logic [BTN_W-1:0]        b;
		logic [ADR_W-1:0]        tmr, gpio;
		rst_n = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		sel = '0;
		wdat = '0;
		btn = '0;
		seg_value = '0;
		seg_check_on = 1'b0;
		tmr = base_addr(TIMER_BASE);
		gpio = base_addr(GPIO_BASE);
		repeat (RST_CYCLES) @(negedge clk);
		// Reset values before the first free edge
		compare("reset ack", 32'd0, 32'(ack));
		compare("reset err", 32'd0, 32'(err));
		compare("reset led", 32'd0, 32'(led));
		compare("reset irq", 32'd0, 32'(irq));
		compare("reset anode", 32'(4'b1110), 32'(an));
		rst_n = 1'b1;
		@(negedge clk);

		// RAM fill, random partial writes and read back
		for (int i = 0; i < RAM_TESTS; i++) begin
			r = next_rand();
			ram_idx[i] = r[WIDX_W-1:0];
			ram_model[ram_idx[i]] = fill_word(ram_idx[i]);
			write_reg(base_addr(BRAM_BASE) | (32'(ram_idx[i]) << 2), ram_model[ram_idx[i]]);
		end
		for (int i = 0; i < RAM_TESTS; i++) begin
			r = next_rand();
			lanes = r[SEL_W-1:0];
			r = next_rand();
			ram_model[ram_idx[i]] = merge_bytes(ram_model[ram_idx[i]], r, lanes);
			bus_access(1'b1, base_addr(BRAM_BASE) | (32'(ram_idx[i]) << 2), lanes, r, q, resp);
			compare("ram write resp", 32'(RESP_ACK), 32'(resp));
		end
		for (int i = 0; i < RAM_TESTS; i++) begin
			read_reg(base_addr(BRAM_BASE) | (32'(ram_idx[i]) << 2), q);
			compare($sformatf("ram word %0d", ram_idx[i]), ram_model[ram_idx[i]], q);
		end

		// Unmapped address ends with err only
		bus_access(1'b0, 32'h8000_0000, '1, '0, q, resp);
		compare("unmapped resp", 32'(RESP_ERR), 32'(resp));
		write_reg(base_addr(BRAM_BASE), 32'h5a5a_c3c3);
		read_reg(base_addr(BRAM_BASE), q);
		compare("ram after err", 32'h5a5a_c3c3, q);

		// Timer 0 one-shot
		write_reg(tmr | 32'(TMR_CMP0), 32'd50);
		write_reg(tmr | 32'(TMR_CTRL0), 32'(1) << CTRL_EN);
		poll_flag(tmr | 32'(TMR_CTRL0), "timer0");
		compare("timer0 irq", 32'd1, 32'(irq[IRQ_TMR0]));
		read_reg(tmr | 32'(TMR_CTRL0), q);
		compare("timer0 ctrl", 32'(1) << CTRL_IRQ, q);
		read_reg(tmr | 32'(TMR_CNT0), q);
		compare("timer0 count", 32'd0, q);
		write_reg(tmr | 32'(TMR_CTRL0), 32'(1) << CTRL_IRQ);
		compare("timer0 irq clear", 32'd0, 32'(irq[IRQ_TMR0]));

		// Timer 1 auto-reload over two matches
		write_reg(tmr | 32'(TMR_CMP1), 32'd20);
		write_reg(tmr | 32'(TMR_CTRL1), (32'(1) << CTRL_EN) | (32'(1) << CTRL_AR));
		poll_flag(tmr | 32'(TMR_CTRL1), "timer1 first");
		compare("timer1 irq", 32'd1, 32'(irq[IRQ_TMR1]));
		r = (32'(1) << CTRL_IRQ) | (32'(1) << CTRL_EN) | (32'(1) << CTRL_AR);
		write_reg(tmr | 32'(TMR_CTRL1), r);
		poll_flag(tmr | 32'(TMR_CTRL1), "timer1 second");
		read_reg(tmr | 32'(TMR_CTRL1), q);
		compare("timer1 ctrl", r, q);
		write_reg(tmr | 32'(TMR_CTRL1), 32'(1) << CTRL_IRQ);
		compare("timer1 irq clear", 32'd0, 32'(irq[IRQ_TMR1]));

		// GPIO output, buttons and mask
		r = next_rand();
		write_reg(gpio | 32'(GPIO_OUT), r);
		compare("gpio led", 32'(r[LED_W-1:0]), 32'(led));
		read_reg(gpio | 32'(GPIO_OUT), q);
		compare("gpio out", r, q);
		r = next_rand();
		b = r[BTN_W-1:0] | 4'b0001;
		btn = b;
		repeat (4) @(negedge clk);
		read_reg(gpio | 32'(GPIO_IN), q);
		compare("gpio in", 32'(b) << BTN_LSB, q);
		write_reg(gpio | 32'(GPIO_MASK), 32'(1) << BTN_LSB);
		compare("gpio irq masked in", 32'd1, 32'(irq[IRQ_GPIO]));
		write_reg(gpio | 32'(GPIO_MASK), 32'd0);
		compare("gpio irq masked out", 32'd0, 32'(irq[IRQ_GPIO]));
		btn = '0;

		// Display shows each value for one full scan, all sixteen glyphs in turn
		for (int k = 0; k < SHOW_VALUES; k++) begin
			r = next_rand();
			seg_value = {4'(4*k + 3), 4'(4*k + 2), 4'(4*k + 1), 4'(4*k)};
			write_reg(gpio | 32'(GPIO_OUT), {r[31:16], seg_value});
			seg_check_on = 1'b1;
			repeat (SCAN_PERIOD) @(negedge clk);
			seg_check_on = 1'b0;
		end

		$display("sim passed");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYC) @(posedge clk);
		abort_run("watchdog expired before the tests finished");
	end

endmodule

//--- filelist.f
verilog/soc_pkg.sv
verilog/bus_decoder.sv
verilog/bram_slave.sv
verilog/timer_slave.sv
verilog/gpio_slave.sv
verilog/sevenseg_scan.sv
verilog/soc_top.sv
test/soc_sva.sv
test/tb_soc.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the soc_top testbench with Verilator
# Exit status is nonzero when the testbench stops with $fatal
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module tb_soc -o tb_soc

./obj_dir/tb_soc
